//--- list.f
+incdir+hw
hw/wavegen_pkg.sv
hw/apb_wavegen_regs.sv
hw/phase_timer.sv
hw/shape_core.sv
hw/frame_sequencer.sv
hw/wavegen_top.sv
tests/wavegen_sva.sv
tests/wavegen_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f list.f --top-module wavegen_tb -o wavegen_sim > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/wavegen_sim > sim.log 2>&1 \
    || echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

//--- tests/wavegen_tb.sv
`include "wavegen_cfg.svh"

module wavegen_tb
    import wavegen_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N = `WG_N_CHANNELS;
    localparam int MAX_CYCLES = 5000;  // the tests need about 800 cycles.

    logic         clock;
    logic         rst_n;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    logic         trigger;
    wg_beat_t     beat;
    logic         beat_valid;
    logic         beat_ready;
    logic         busy;
    wg_chan_cfg_t exp_cfg [N];  // reference model of each channel.
    int           exp_phase [N];
    bit           random_ready;
    string        current_test;
    int           checks;
    int           errors;
    int           test_errors;
    int           tests_passed;
    int           tests_failed;
    int           cycle_count;

    wavegen_top dut_i (
        .clock(clock), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .trigger(trigger), .beat(beat), .beat_valid(beat_valid),
        .beat_ready(beat_ready), .busy(busy)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s (%s): expected 0x%0h, actual 0x%0h",
                     current_test, name, expected, actual);
            errors++;
        end
    endtask

    // Setup phase, then the access phase; the response is sampled mid-cycle.
    task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clock);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(negedge clock);
        apb_req.penable = 1'b1;
        #1;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clock);
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value($sformatf("write 0x%02h pslverr", addr), 0, err);
    endtask

    task automatic read_check(input string name, input logic [7:0] addr,
                              input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check_value(name, expected, rdata);
        check_value({name, " pslverr"}, 0, err);
    endtask

    task automatic configure(input int ch, input wg_shape_e shape, input logic [15:0] period,
                             input logic [31:0] param);
        write_reg(REG_SHAPE, 32'(shape));
        write_reg(REG_SELECT, ch);
        write_reg(REG_PERIOD, 32'(period));
        write_reg(REG_PARAM, param);
        write_reg(REG_COMMIT, 32'h0);
        exp_cfg[ch].shape  = shape;
        exp_cfg[ch].period = period;
        exp_cfg[ch].param  = param;
        exp_phase[ch]      = 0;  // a commit restarts the channel.
    endtask

    function automatic logic [15:0] model_sample(input wg_chan_cfg_t c, input int phase);
        bit first_half;
        int ramp_phase;
        int value;
        first_half = (2 * phase < int'(c.period));
        ramp_phase = (c.shape == WG_TRIANGLE && !first_half) ? int'(c.period) - phase : phase;
        value      = int'(c.param.ramp.offset) + int'(c.param.ramp.step) * ramp_phase;
        case (c.shape)
            WG_SQUARE: return first_half ? c.param.levels.high_level : c.param.levels.low_level;
            WG_SAWTOOTH, WG_TRIANGLE: return value[15:0];
            default: return 16'h0;
        endcase
    endfunction

    function automatic void model_advance(input int ch);
        if (int'(exp_cfg[ch].period) <= 1 || exp_phase[ch] + 1 >= int'(exp_cfg[ch].period)) begin
            exp_phase[ch] = 0;
        end else begin
            exp_phase[ch]++;
        end
    endfunction

    // Called on a falling edge; a beat seen with ready high transfers on the next rising edge.
    task automatic take_beat(input string name, input int ch, input logic last);
        beat_ready = random_ready ? ($urandom % 2 == 0) : 1'b1;
        while (!(beat_valid && beat_ready)) begin
            @(negedge clock);
            beat_ready = random_ready ? ($urandom % 2 == 0) : 1'b1;
        end
        check_value({name, " channel"}, ch, 32'(beat.chan));
        check_value({name, " sample"}, 32'(model_sample(exp_cfg[ch], exp_phase[ch])),
                    32'(beat.sample));
        check_value({name, " last"}, 32'(last), 32'(beat.last));
        model_advance(ch);
        @(negedge clock);
    endtask

    task automatic pulse_trigger();
        @(negedge clock);
        trigger = 1'b1;
        @(negedge clock);
        trigger = 1'b0;
    endtask

    task automatic run_frame(input string name, input logic [N-1:0] mask);
        int top;
        top = 0;
        for (int i = 0; i < N; i++) begin
            if (mask[i]) top = i;
        end
        pulse_trigger();
        for (int i = 0; i < N; i++) begin
            if (mask[i]) take_beat(name, i, i == top);
        end
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            check_value({name, " beat_valid"}, 0, 32'(beat_valid));
            check_value({name, " busy"}, 0, 32'(busy));
            @(negedge clock);
        end
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("PASS %s", current_test);
            tests_passed++;
        end else begin
            $display("%s had %0d failed checks", current_test, errors - test_errors);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        void'($urandom(32'hf5cc));
        rst_n = 1'b0;
        apb_req = '0;
        trigger = 1'b0;
        beat_ready = 1'b0;
        random_ready = 1'b0;
        exp_phase = '{default: 0};
        repeat (10) @(negedge clock);
        rst_n = 1'b1;

        current_test = "register access";
        write_reg(REG_ENABLE, 32'h3);
        write_reg(REG_SHAPE, 32'h2);
        write_reg(REG_SELECT, 32'h1);
        write_reg(REG_PERIOD, 32'h1234);
        write_reg(REG_PARAM, 32'hdead_beef);
        read_check("enable readback", REG_ENABLE, 32'h3);
        read_check("shape readback", REG_SHAPE, 32'h2);
        read_check("select readback", REG_SELECT, 32'h1);
        read_check("period readback", REG_PERIOD, 32'h1234);
        read_check("param readback", REG_PARAM, 32'hdead_beef);
        read_check("commit readback", REG_COMMIT, 32'h0);
        apb_access(1'b1, 8'h18, 32'hffff_ffff, rdata, err);
        check_value("write 0x18 pslverr", 1, err);
        apb_access(1'b1, 8'h03, 32'h0, rdata, err);  // would clear the mask if it decoded.
        check_value("write 0x03 pslverr", 1, err);
        apb_access(1'b0, 8'h03, 32'h0, rdata, err);
        check_value("read 0x03 pslverr", 1, err);
        read_check("enable after bad writes", REG_ENABLE, 32'h3);
        read_check("param after bad writes", REG_PARAM, 32'hdead_beef);
        end_test();

        current_test = "square wave";
        configure(0, WG_SQUARE, 16'd4, {16'h1234, 16'h0010});
        write_reg(REG_ENABLE, 32'h1);
        repeat (8) run_frame("square", 2'b01);
        end_test();

        current_test = "sawtooth and triangle";
        configure(0, WG_SAWTOOTH, 16'd5, {16'd3, 16'd100});
        configure(1, WG_TRIANGLE, 16'd6, {16'd10, 16'd0});
        write_reg(REG_ENABLE, 32'h3);
        repeat (12) run_frame("ramps", 2'b11);
        end_test();

        current_test = "enable handling";
        write_reg(REG_ENABLE, 32'h2);
        run_frame("mask 0b10", 2'b10);
        write_reg(REG_ENABLE, 32'h0);
        pulse_trigger();
        expect_quiet("mask 0", 4);
        write_reg(REG_ENABLE, 32'h3);
        @(negedge clock);
        beat_ready = 1'b0;
        pulse_trigger();
        pulse_trigger();  // arrives while the first frame is stalled.
        take_beat("busy trigger", 0, 1'b0);
        take_beat("busy trigger", 1, 1'b1);
        expect_quiet("busy trigger", 4);
        end_test();

        current_test = "back-pressure";
        random_ready = 1'b1;
        repeat (20) run_frame("backpressure", 2'b11);
        random_ready = 1'b0;
        end_test();

        current_test = "commit restart";
        configure(0, WG_TRIANGLE, 16'd8, {16'd7, 16'h0200});
        repeat (3) run_frame("recommit", 2'b11);
        end_test();

        $display("%0d tests passed, %0d tests failed, %0d of %0d checks failed",
                 tests_passed, tests_failed, errors, checks);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tests/wavegen_sva.sv
`include "wavegen_cfg.svh"

module wavegen_sva
    import wavegen_pkg::*;
(
    input logic                      clock,
    input logic                      rst_n,
    input apb_req_t                  apb_req,
    input apb_rsp_t                  apb_rsp,
    input logic                      trigger,
    input logic [`WG_N_CHANNELS-1:0] enable,
    input wg_beat_t                  beat,
    input logic                      beat_valid,
    input logic                      beat_ready,
    input logic                      busy
);

    timeunit 1ns;
    timeprecision 100ps;

    logic                      access;
    logic                      bad_addr;
    logic [`WG_N_CHANNELS-1:0] frame_mask;  // channels enabled when the frame started.
    logic [`WG_N_CHANNELS-1:0] higher;

    assign access   = apb_req.psel & apb_req.penable;
    assign bad_addr = (apb_req.paddr > REG_COMMIT) || (apb_req.paddr[1:0] != 2'b00);
    assign higher   = (frame_mask >> beat.chan) >> 1;  // enabled channels above this beat.

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            frame_mask <= '0;
        end else if (trigger && !busy) begin
            frame_mask <= enable;
        end
    end

    a_pready: assert property (@(posedge clock) disable iff (!rst_n)
        access |-> apb_rsp.pready) else $error("pready low in an APB access cycle");

    a_pslverr: assert property (@(posedge clock) disable iff (!rst_n)
        apb_rsp.pslverr == (access && bad_addr)) else $error("pslverr does not match the address");

    a_stall: assert property (@(posedge clock) disable iff (!rst_n)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat))
        else $error("stalled beat changed before it was accepted");

    a_busy: assert property (@(posedge clock) disable iff (!rst_n)
        beat_valid |-> busy) else $error("beat_valid high while not busy");

    a_last: assert property (@(posedge clock) disable iff (!rst_n)
        beat_valid |-> (beat.last == (higher == '0))) else $error("last flag on the wrong channel");

endmodule

bind wavegen_top wavegen_sva sva_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .trigger    (trigger),
    .enable     (enable),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .busy       (busy)
);

//--- hw/wavegen_top.sv
`include "wavegen_cfg.svh"

module wavegen_top
    import wavegen_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  logic     trigger,
    output wg_beat_t beat,
    output logic     beat_valid,
    input  logic     beat_ready,
    output logic     busy
);

    logic [`WG_N_CHANNELS-1:0]                   enable;
    wg_chan_cfg_t [`WG_N_CHANNELS-1:0]           cfg;
    logic [`WG_N_CHANNELS-1:0]                   commit;
    logic [`WG_N_CHANNELS-1:0]                   advance;
    logic [`WG_N_CHANNELS-1:0][`WG_PERIOD_W-1:0] phase;
    logic [`WG_N_CHANNELS-1:0][`WG_SAMPLE_W-1:0] samples;

    apb_wavegen_regs regs_i (
        .clock   (clock),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .enable  (enable),
        .cfg     (cfg),
        .commit  (commit)
    );

    // One timer and one shape core per channel.
    for (genvar ch = 0; ch < `WG_N_CHANNELS; ch++) begin : g_chan
        phase_timer timer_i (
            .clock   (clock),
            .rst_n   (rst_n),
            .period  (cfg[ch].period),
            .advance (advance[ch]),
            .clear   (commit[ch]),
            .phase   (phase[ch])
        );

        shape_core core_i (
            .cfg    (cfg[ch]),
            .phase  (phase[ch]),
            .sample (samples[ch])
        );
    end

    frame_sequencer seq_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .trigger    (trigger),
        .enable     (enable),
        .samples    (samples),
        .advance    (advance),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .busy       (busy)
    );

endmodule

//--- hw/frame_sequencer.sv
`include "wavegen_cfg.svh"

module frame_sequencer
    import wavegen_pkg::*;
(
    input  logic                                         clock,
    input  logic                                         rst_n,
    input  logic                                         trigger,
    input  logic [`WG_N_CHANNELS-1:0]                    enable,
    input  logic [`WG_N_CHANNELS-1:0][`WG_SAMPLE_W-1:0]  samples,
    output logic [`WG_N_CHANNELS-1:0]                    advance,
    output wg_beat_t                                     beat,
    output logic                                         beat_valid,
    input  logic                                         beat_ready,
    output logic                                         busy
);

    typedef enum logic [1:0] {
        IDLE,
        EMIT,   // a beat is out and more channels follow it.
        DRAIN   // the last beat of the frame is out.
    } seq_state_e;

    seq_state_e                state;
    logic [`WG_N_CHANNELS-1:0] pending;  // channels still to send in this frame.
    logic [`WG_N_CHANNELS-1:0] search;
    logic [`WG_N_CHANNELS-1:0] first_oh;
    logic [`WG_N_CHANNELS-1:0] remaining;
    logic [`WG_CHAN_W-1:0]     first_idx;
    logic [`WG_SAMPLE_W-1:0]   first_sample;
    logic                      accept;

    assign beat_valid = (state != IDLE);
    assign busy       = (state != IDLE);
    assign accept     = beat_valid & beat_ready;

    // In IDLE the live enable mask is searched, so the frame uses the mask seen at trigger.
    assign search = (state == IDLE) ? enable : pending;

    // the lowest set bit wins the priority search.
    always_comb begin
        first_oh     = '0;
        first_idx    = '0;
        first_sample = '0;
        for (int i = `WG_N_CHANNELS - 1; i >= 0; i--) begin
            if (search[i]) begin
                first_oh     = '0;
                first_oh[i]  = 1'b1;
                first_idx    = i[`WG_CHAN_W-1:0];
                first_sample = samples[i];
            end
        end
    end

    assign remaining = search & ~first_oh;

    always_comb begin
        advance = '0;
        for (int i = 0; i < `WG_N_CHANNELS; i++) begin
            if (accept && beat.chan == i[`WG_CHAN_W-1:0]) begin
                advance[i] = 1'b1;  // the timer steps on the acceptance edge.
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= IDLE;
            pending <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (trigger && enable != '0) begin
                        pending <= remaining;
                        state   <= (remaining == '0) ? DRAIN : EMIT;
                    end
                end
                EMIT: begin
                    if (accept) begin
                        pending <= remaining;
                        state   <= (remaining == '0) ? DRAIN : EMIT;
                    end
                end
                DRAIN: begin
                    if (accept) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the sample is captured in the payload register so it holds under back-pressure.
    always_ff @(posedge clock) begin
        if ((state == IDLE && trigger && enable != '0) || (state == EMIT && accept)) begin
            beat.chan   <= first_idx;
            beat.sample <= first_sample;
            beat.last   <= (remaining == '0);
        end
    end

endmodule

//--- hw/shape_core.sv
`include "wavegen_cfg.svh"

module shape_core
    import wavegen_pkg::*;
(
    input  wg_chan_cfg_t            cfg,
    input  logic [`WG_PERIOD_W-1:0] phase,
    output logic [`WG_SAMPLE_W-1:0] sample
);

    logic                                 first_half;
    logic [`WG_PERIOD_W-1:0]              folded;
    logic [`WG_PERIOD_W-1:0]              ramp_phase;
    logic [`WG_SAMPLE_W+`WG_PERIOD_W-1:0] product;
    logic [`WG_SAMPLE_W-1:0]              ramp_value;

    // Compare 2*phase against the period with one extra bit so nothing overflows.
    assign first_half = ({phase, 1'b0} < {1'b0, cfg.period});

    // The triangle climbs until mid-period and then walks back down.
    assign folded = first_half ? phase : cfg.period - phase;

    assign ramp_phase = (cfg.shape == WG_TRIANGLE) ? folded : phase;

    assign product = cfg.param.ramp.step * ramp_phase;

    // Sample arithmetic wraps modulo the sample width.
    assign ramp_value = cfg.param.ramp.offset + product[`WG_SAMPLE_W-1:0];

    always_comb begin
        case (cfg.shape)
            WG_SQUARE: begin
                if (first_half) begin
                    sample = cfg.param.levels.high_level;
                end else begin
                    sample = cfg.param.levels.low_level;
                end
            end
            WG_SAWTOOTH: sample = ramp_value;
            WG_TRIANGLE: sample = ramp_value;
            default:     sample = '0;  // reserved shape.
        endcase
    end

endmodule

//--- hw/phase_timer.sv
`include "wavegen_cfg.svh"

module phase_timer (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic [`WG_PERIOD_W-1:0] period,
    input  logic                    advance,
    input  logic                    clear,
    output logic [`WG_PERIOD_W-1:0] phase
);

    logic [`WG_PERIOD_W-1:0] last_phase;
    logic                    at_end;

    // A zero period is treated like a period of one.
    assign last_phase = (period == '0) ? '0 : period - 1'b1;

    // >= also catches a phase left beyond a shortened period.
    assign at_end = (phase >= last_phase);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (clear) begin
            phase <= '0;  // a new configuration starts from the beginning.
        end else if (advance) begin
            if (at_end) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

endmodule

//--- hw/apb_wavegen_regs.sv
`include "wavegen_cfg.svh"

module apb_wavegen_regs
    import wavegen_pkg::*;
(
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  apb_req_t                              apb_req,
    output apb_rsp_t                              apb_rsp,
    output logic [`WG_N_CHANNELS-1:0]             enable,
    output wg_chan_cfg_t [`WG_N_CHANNELS-1:0]     cfg,
    output logic [`WG_N_CHANNELS-1:0]             commit
);

    logic                    access;
    logic                    addr_ok;
    logic                    wr_en;
    wg_shape_e               stage_shape;
    logic [`WG_CHAN_W-1:0]   stage_select;
    logic [`WG_PERIOD_W-1:0] stage_period;
    wg_param_u               stage_param;
    wg_chan_cfg_t            staged_cfg;

    assign access  = apb_req.psel & apb_req.penable;  // the access phase of a transfer.
    assign addr_ok = (apb_req.paddr <= REG_COMMIT) && (apb_req.paddr[1:0] == 2'b00);
    assign wr_en   = access & apb_req.pwrite & addr_ok;

    always_comb begin
        staged_cfg.shape  = stage_shape;
        staged_cfg.period = stage_period;
        staged_cfg.param  = stage_param;
    end

    // The commit strobe is decoded in the access cycle, so the timer clears
    // on the same edge that loads the new channel configuration.
    always_comb begin
        commit = '0;
        if (wr_en && apb_req.paddr == REG_COMMIT) begin
            for (int i = 0; i < `WG_N_CHANNELS; i++) begin
                if (stage_select == i[`WG_CHAN_W-1:0]) begin
                    commit[i] = 1'b1;  // out-of-range selects match no channel.
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            enable       <= '0;
            stage_shape  <= WG_SQUARE;
            stage_select <= '0;
            stage_period <= '0;
            stage_param  <= '0;
        end else if (wr_en) begin
            case (apb_req.paddr)
                REG_ENABLE: enable       <= apb_req.pwdata[`WG_N_CHANNELS-1:0];
                REG_SHAPE:  stage_shape  <= wg_shape_e'(apb_req.pwdata[1:0]);
                REG_SELECT: stage_select <= apb_req.pwdata[`WG_CHAN_W-1:0];
                REG_PERIOD: stage_period <= apb_req.pwdata[`WG_PERIOD_W-1:0];
                REG_PARAM:  stage_param  <= apb_req.pwdata;
                default: ;  // commit is handled by the strobe decode.
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cfg <= '0;
        end else begin
            for (int i = 0; i < `WG_N_CHANNELS; i++) begin
                if (commit[i]) begin
                    cfg[i] <= staged_cfg;
                end
            end
        end
    end

    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;  // no wait states.
        apb_rsp.pslverr = access & ~addr_ok;
        case (apb_req.paddr)
            REG_ENABLE: apb_rsp.prdata[`WG_N_CHANNELS-1:0] = enable;
            REG_SHAPE:  apb_rsp.prdata[1:0]                = stage_shape;
            REG_SELECT: apb_rsp.prdata[`WG_CHAN_W-1:0]     = stage_select;
            REG_PERIOD: apb_rsp.prdata[`WG_PERIOD_W-1:0]   = stage_period;
            REG_PARAM:  apb_rsp.prdata                     = stage_param;
            default: ;
        endcase
    end

endmodule

//--- hw/wavegen_pkg.sv
`include "wavegen_cfg.svh"

package wavegen_pkg;

    typedef enum logic [1:0] {
        WG_SQUARE   = 2'd0,
        WG_SAWTOOTH = 2'd1,
        WG_TRIANGLE = 2'd2,
        WG_RESERVED = 2'd3  // outputs zero.
    } wg_shape_e;

    typedef struct packed {
        logic [`WG_SAMPLE_W-1:0] high_level;
        logic [`WG_SAMPLE_W-1:0] low_level;
    } wg_levels_t;

    typedef struct packed {
        logic [`WG_SAMPLE_W-1:0] step;
        logic [`WG_SAMPLE_W-1:0] offset;
    } wg_ramp_t;

    // square reads the word as two levels, the ramps read it as step and offset.
    typedef union packed {
        wg_levels_t levels;
        wg_ramp_t   ramp;
    } wg_param_u;

    typedef struct packed {
        wg_shape_e               shape;
        logic [`WG_PERIOD_W-1:0] period;
        wg_param_u               param;
    } wg_chan_cfg_t;

    typedef struct packed {
        logic [`WG_CHAN_W-1:0]   chan;
        logic [`WG_SAMPLE_W-1:0] sample;
        logic                    last;  // final beat of the frame.
    } wg_beat_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [7:0] REG_ENABLE = 8'h00;
    localparam logic [7:0] REG_SHAPE  = 8'h04;
    localparam logic [7:0] REG_SELECT = 8'h08;
    localparam logic [7:0] REG_PERIOD = 8'h0C;
    localparam logic [7:0] REG_PARAM  = 8'h10;
    localparam logic [7:0] REG_COMMIT = 8'h14;  // write-only strobe register.

endpackage

//--- hw/wavegen_cfg.svh
`ifndef WAVEGEN_CFG_SVH
`define WAVEGEN_CFG_SVH

// number of generator channels; the design also runs with 4.
`define WG_N_CHANNELS 2

`define WG_SAMPLE_W 16  // output sample width.
`define WG_PERIOD_W 16  // period and phase counter width.

// channel index width carried on the output stream.
`define WG_CHAN_W 4

`endif
